// File: cpu16.f
+incdir+include
hw/alu_pkg.sv
hw/types_pkg.sv
hw/prog_loader.sv
hw/mem_program.sv
hw/reg_program_counter.sv
hw/control_main.sv
hw/mem_register.sv
hw/alu.sv
hw/result_port.sv
hw/cpu_top.sv
testbench/cpu_tb.sv

// File: include/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Instruction builders
function automatic types_pkg::word_16 enc_alu(input logic [3:0] rd, input logic [3:0] rb,
		input alu_pkg::control_e func);
	return {types_pkg::op_alu, rd, rb, func};
endfunction

function automatic types_pkg::word_16 enc_li(input logic [3:0] rd, input logic [7:0] imm8);
	return {types_pkg::op_li, rd, imm8};
endfunction

function automatic types_pkg::word_16 enc_skz(input logic [3:0] rd);
	return {types_pkg::op_skz, rd, 8'h00};
endfunction

function automatic types_pkg::word_16 enc_halt();
	return {types_pkg::op_halt, 12'h000};
endfunction

// ALU model where func codes above 6 pass b
function automatic types_pkg::word_16 model_alu(input types_pkg::word_16 a,
		input types_pkg::word_16 b, input logic [3:0] func, output alu_pkg::status_t st);
	types_pkg::word_16 r;
	st = '0;
	case (func)
		4'h0: begin
			r = a + b;
			// Carry out whenever the sum wraps
			st.carry = (r < a);
			st.overflow = (a[15] == b[15]) && (r[15] != a[15]);
		end
		4'h1: begin
			r = a - b;
			// Carry set means no borrow
			st.carry = (a >= b);
			st.overflow = (a[15] != b[15]) && (r[15] != a[15]);
		end
		4'h2: r = a & b;
		4'h3: r = a | b;
		4'h4: r = a ^ b;
		4'h5: begin
			r = a << 1;
			st.carry = a[15];
		end
		4'h6: begin
			r = a >> 1;
			st.carry = a[0];
		end
		default: r = b;
	endcase
	st.zero = (r == '0);
	st.negative = r[15];
	return r;
endfunction

// Runs a program from word zero on the model registers
// Returns 1 when a halt is reached
function automatic bit model_run(input types_pkg::word_16 prog[$],
		ref types_pkg::word_16 regs[16], output int unsigned retired,
		inout alu_pkg::status_t st);
	types_pkg::instr_t ins;
	alu_pkg::status_t alu_st;
	int unsigned pc;
	int unsigned steps;
	byte imm;
	pc = 0;
	retired = 0;
	for (steps = 0; steps < 4096; steps++) begin
		if (pc >= prog.size()) begin
			return 1'b0;
		end
		ins = types_pkg::instr_t'(prog[pc]);
		case (ins.opcode)
			types_pkg::op_alu: begin
				regs[ins.rd] = model_alu(regs[ins.rd], regs[ins.rb], ins.func, alu_st);
				st = alu_st;
			end
			types_pkg::op_li: begin
				// Signed byte widened to a word
				imm = prog[pc][7:0];
				regs[ins.rd] = types_pkg::word_16'(int'(imm));
			end
			types_pkg::op_skz: begin
				if (regs[ins.rd] == '0) begin
					pc++;
				end
			end
			types_pkg::op_halt: return 1'b1;
			default: ;
		endcase
		retired++;
		pc++;
	end
	return 1'b0;
endfunction

`endif

// File: testbench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import types_pkg::*;
	import alu_pkg::*;

	`include "cpu_model.svh"

	// Cycle limits for the two kinds of wait
	localparam int HALT_TIMEOUT = 2000;
	localparam int CHECK_TIMEOUT = 200;

	logic clk;
	logic reset;
	load_t load;
	logic start;
	reg_addr_t dbg_addr;
	word_16 dbg_data;
	logic halted;
	status_t status;
	logic [15:0] retired;

	// Expected machine state
	// Registers carry across runs just like the DUT
	word_16 exp_regs [16];
	int unsigned exp_retired;
	status_t exp_status;

	// Request flag to the compare process
	// Cleared by that process once done
	bit check_req;
	int check_errors;
	bit timed_out;
	int tests_run;
	int tests_failed;

	cpu_top DUT (
		.clk     (clk),
		.reset   (reset),
		.load    (load),
		.start   (start),
		.dbg_addr(dbg_addr),
		.dbg_data(dbg_data),
		.halted  (halted),
		.status  (status),
		.retired (retired)
	);

	always #2 clk = ~clk;

	// Walks all registers over the debug port
	// Summary outputs after that
	task automatic compare_state();
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			dbg_addr = reg_addr_t'(i);
			#1;
			if (dbg_data !== exp_regs[i]) begin
				$display("FAILED dbg_data (r%0d): got %h expected %h", i, dbg_data, exp_regs[i]);
				check_errors++;
			end
		end
		if (retired !== exp_retired[15:0]) begin
			$display("FAILED retired: got %h expected %h", retired, exp_retired[15:0]);
			check_errors++;
		end
		if (status !== exp_status) begin
			$display("FAILED status: got %h expected %h", status, exp_status);
			check_errors++;
		end
	endtask

	// Compare process
	initial begin
		forever begin
			@(negedge clk);
			if (check_req) begin
				compare_state();
				check_req = 1'b0;
			end
		end
	end

	// One word per cycle over the load port
	task automatic load_program(input word_16 prog[$]);
		for (int i = 0; i < prog.size(); i++) begin
			@(negedge clk);
			load.valid = 1'b1;
			load.addr = prog_addr_t'(i);
			load.data = prog[i];
		end
		@(negedge clk);
		load = '0;
	endtask

	task automatic start_run();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// Halt words aimed ahead of the PC plus a stray start
	// All of it lands while the core runs
	// Start falls after the r5 shift so a restart would redo it
	task automatic drive_while_running();
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			load.valid = (i < 4);
			load.addr = prog_addr_t'(8 + i);
			load.data = enc_halt();
			start = (i == 8);
		end
		@(negedge clk);
		load = '0;
		start = 1'b0;
	endtask

	task automatic wait_halted(input string name, output bit ok);
		int cycles;
		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		ok = halted;
		if (!ok) begin
			timed_out = 1'b1;
			$display("timeout: %s did not halt within %0d cycles", name, HALT_TIMEOUT);
		end
	endtask

	// Waits for halt, runs the model, hands off to the compare process
	task automatic finish_run(input string name, input word_16 prog[$]);
		bit ok;
		bit reached;
		int unsigned ret;
		int cycles;
		// The start edge clears halted left from an earlier run
		check_errors = 0;
		if (halted !== 1'b0) begin
			$display("FAILED halted: got %h expected %h", halted, 1'b0);
			check_errors++;
		end
		wait_halted(name, ok);
		tests_run++;
		if (!ok) begin
			tests_failed++;
			$display("test %s: stopped, the DUT never halted", name);
			return;
		end
		reached = model_run(prog, exp_regs, ret, exp_status);
		exp_retired = ret;
		if (!reached) begin
			tests_failed++;
			$display("test %s: the model never reached a halt", name);
			return;
		end
		check_req = 1'b1;
		cycles = 0;
		while (check_req && cycles < CHECK_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (check_req) begin
			timed_out = 1'b1;
			tests_failed++;
			$display("test %s: stopped, the compare process did not finish", name);
		end else if (check_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, check_errors);
		end
	endtask

	task automatic run_test(input string name, input word_16 prog[$]);
		if (timed_out) begin
			return;
		end
		load_program(prog);
		start_run();
		finish_run(name, prog);
	endtask

	// Eight load immediates, then random ALU ops, then halt
	task automatic build_random(input int n_ops, output word_16 prog[$]);
		prog.delete();
		for (int r = 0; r < 8; r++) begin
			prog.push_back(enc_li(4'(r), 8'($urandom_range(255, 0))));
		end
		for (int k = 0; k < n_ops; k++) begin
			prog.push_back(enc_alu(4'($urandom_range(15, 0)), 4'($urandom_range(15, 0)),
				control_e'($urandom_range(7, 0))));
		end
		prog.push_back(enc_halt());
	endtask

	initial begin
		word_16 prog[$];
		void'($urandom(32'hb3c6));
		clk = 1'b0;
		reset = 1'b1;
		load = '0;
		start = 1'b0;
		dbg_addr = '0;
		check_req = 1'b0;
		check_errors = 0;
		timed_out = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		exp_retired = 0;
		exp_status = '0;
		for (int i = 0; i < 16; i++) begin
			exp_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Random ALU programs
		for (int t = 0; t < 4; t++) begin
			build_random(24, prog);
			run_test($sformatf("random_%0d", t), prog);
		end

		// Sign extension of imm8 over both halves of the range
		prog = '{enc_li(4'h4, 8'h80), enc_li(4'h5, 8'h7f), enc_li(4'h6, 8'hff),
			enc_li(4'h7, 8'h01), enc_halt()};
		run_test("li_sign", prog);

		// r8 should stay clear while r9 and r10 get their markers
		prog = '{enc_li(4'h1, 8'h00), enc_li(4'h2, 8'h05), enc_li(4'h8, 8'h00),
			enc_li(4'h9, 8'h00), enc_li(4'ha, 8'h00), enc_skz(4'h1),
			enc_li(4'h8, 8'h11), enc_li(4'h9, 8'h22), enc_skz(4'h2),
			enc_li(4'ha, 8'h33), enc_halt()};
		run_test("skip_zero", prog);

		// Words after the halt must not run
		prog = '{enc_li(4'hb, 8'h12), enc_halt(), enc_li(4'hb, 8'h55),
			enc_li(4'hc, 8'h66), enc_alu(4'hb, 4'hc, alu_add)};
		run_test("halt_stop", prog);

		// Halt at word 13 with stray writes aimed at words 8 to 11
		prog = '{enc_li(4'h1, 8'h03), enc_li(4'h2, 8'hfe), enc_li(4'h3, 8'h40),
			enc_alu(4'h3, 4'h0, alu_shl), enc_alu(4'h3, 4'h1, alu_add),
			enc_alu(4'h1, 4'h2, alu_sub), enc_alu(4'h2, 4'h3, alu_and),
			enc_alu(4'h4, 4'h3, alu_pass_b), enc_alu(4'h5, 4'h1, alu_or),
			enc_alu(4'h5, 4'h0, alu_shr), enc_alu(4'h6, 4'h5, alu_xor),
			enc_alu(4'h2, 4'h2, alu_add), enc_alu(4'h1, 4'h1, alu_sub), enc_halt()};
		if (!timed_out) begin
			load_program(prog);
			start_run();
			drive_while_running();
			finish_run("load_while_running", prog);
		end

		// Restart from zero on top of the registers left behind
		prog = '{enc_alu(4'h3, 4'h1, alu_add), enc_alu(4'h3, 4'h2, alu_sub),
			enc_alu(4'h4, 4'h3, alu_xor), enc_halt()};
		run_test("restart_carry", prog);

		$display("summary: %0d tests run, %0d passed, %0d failed",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0 && !timed_out) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end
endmodule

// File: hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic                 clk,
	input  logic                 reset,
	input  types_pkg::load_t     load,
	input  logic                 start,
	input  types_pkg::reg_addr_t dbg_addr,
	output types_pkg::word_16    dbg_data,
	output logic                 halted,
	output alu_pkg::status_t     status,
	output logic [15:0]          retired
);
	import types_pkg::*;
	import alu_pkg::*;

	uword pc_address;
	word_16 instruction;
	instr_t ins;
	ctrl_t ctrl;
	logic skip;
	logic rd_zero;
	logic run;
	logic restart;
	logic mem_we;
	logic reg_we;
	prog_addr_t mem_addr;
	word_16 mem_data;
	word_16 rd1;
	word_16 rd2;
	word_16 imm_ext;
	in_t alu_in;
	word_16 alu_out;
	status_t alu_stat;

	assign ins = instr_t'(instruction);

	// Input side
	prog_loader loader (
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.start    (start),
		.halt_exec(ctrl.halt),
		.mem_we   (mem_we),
		.mem_addr (mem_addr),
		.mem_data (mem_data),
		.run      (run),
		.restart  (restart)
	);

	mem_program program_memory (
		.clk     (clk),
		.we      (mem_we),
		.waddr   (mem_addr),
		.wdata   (mem_data),
		.address (pc_address),
		.data_out(instruction)
	);

	reg_program_counter pc_reg (
		.clk        (clk),
		.reset      (reset),
		.restart    (restart),
		.run        (run),
		.halt_exec  (ctrl.halt),
		.skip       (skip),
		.out_address(pc_address)
	);

	// Skip tests rd on read port one
	assign rd_zero = (rd1 == '0);

	control_main control_unit (
		.instruction(instruction),
		.rd_zero    (rd_zero),
		.ctrl       (ctrl),
		.skip       (skip)
	);

	// Write back only while running
	assign reg_we = run && ctrl.reg_wr;

	mem_register register_file (
		.clk          (clk),
		.reset        (reset),
		.ra1          (ins.rd),
		.ra2          (ins.rb),
		.dbg_addr     (dbg_addr),
		.write_en     (reg_we),
		.write_address(ins.rd),
		.write_data   (alu_out),
		.rd1          (rd1),
		.rd2          (rd2),
		.dbg_data     (dbg_data)
	);

	// Sign-extended imm8 replaces operand b
	assign imm_ext = {{8{ins.rb[3]}}, ins.rb, ins.func};
	assign alu_in.a = rd1;
	assign alu_in.b = ctrl.imm_sel ? imm_ext : rd2;

	alu main_alu (
		.in     (alu_in),
		.control(ctrl.alu_func),
		.out    (alu_out),
		.stat   (alu_stat)
	);

	// Output side
	result_port results (
		.clk     (clk),
		.reset   (reset),
		.restart (restart),
		.run     (run),
		.ctrl    (ctrl),
		.alu_stat(alu_stat),
		.halted  (halted),
		.status  (status),
		.retired (retired)
	);
endmodule

// File: hw/result_port.sv
`timescale 1ns/1ps

module result_port (
	input  logic             clk,
	input  logic             reset,
	input  logic             restart,
	input  logic             run,
	input  types_pkg::ctrl_t ctrl,
	input  alu_pkg::status_t alu_stat,
	output logic             halted,
	output alu_pkg::status_t status,
	output logic [15:0]      retired
);
	logic alu_op;

	// Register writes without the immediate are the ALU ops
	assign alu_op = ctrl.reg_wr && !ctrl.imm_sel;

	always_ff @(posedge clk) begin
		if (reset) begin
			halted <= 1'b0;
			status <= '0;
			retired <= '0;
		end else begin
			// Start clears the run summary
			// Flags stay from the last ALU op
			if (restart) begin
				halted <= 1'b0;
				retired <= '0;
			end else if (run) begin
				if (ctrl.halt) begin
					halted <= 1'b1;
				end else begin
					retired <= retired + 16'd1;
				end
				if (alu_op) begin
					status <= alu_stat;
				end
			end
		end
	end
endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
	input  alu_pkg::in_t      in,
	input  alu_pkg::control_e control,
	output types_pkg::word_16 out,
	output alu_pkg::status_t  stat
);
	import alu_pkg::*;

	// Extra top bit holds the carry
	logic [ALU_W:0] sum;
	logic [ALU_W:0] diff;
	logic add_ovf;
	logic sub_ovf;
	logic carry;
	logic ovf;

	assign sum = {1'b0, in.a} + {1'b0, in.b};
	// a + ~b + 1
	// Top bit set means no borrow
	assign diff = {1'b0, in.a} + {1'b0, ~in.b} + 1'b1;

	// Signed overflow
	assign add_ovf = (in.a[ALU_W-1] == in.b[ALU_W-1]) && (sum[ALU_W-1] != in.a[ALU_W-1]);
	assign sub_ovf = (in.a[ALU_W-1] != in.b[ALU_W-1]) && (diff[ALU_W-1] != in.a[ALU_W-1]);

	always_comb begin
		out = '0;
		carry = 1'b0;
		ovf = 1'b0;
		case (control)
			alu_add: begin
				out = sum[ALU_W-1:0];
				carry = sum[ALU_W];
				ovf = add_ovf;
			end
			alu_sub: begin
				out = diff[ALU_W-1:0];
				carry = diff[ALU_W];
				ovf = sub_ovf;
			end
			alu_and: out = in.a & in.b;
			alu_or:  out = in.a | in.b;
			alu_xor: out = in.a ^ in.b;
			// Shifted-out bit lands in carry
			alu_shl: begin
				out = {in.a[ALU_W-2:0], 1'b0};
				carry = in.a[ALU_W-1];
			end
			alu_shr: begin
				out = {1'b0, in.a[ALU_W-1:1]};
				carry = in.a[0];
			end
			default: out = in.b;
		endcase
	end

	assign stat.zero = (out == '0);
	assign stat.carry = carry;
	assign stat.negative = out[ALU_W-1];
	assign stat.overflow = ovf;
endmodule

// File: hw/mem_register.sv
`timescale 1ns/1ps

module mem_register (
	input  logic                 clk,
	input  logic                 reset,
	input  types_pkg::reg_addr_t ra1,
	input  types_pkg::reg_addr_t ra2,
	input  types_pkg::reg_addr_t dbg_addr,
	input  logic                 write_en,
	input  types_pkg::reg_addr_t write_address,
	input  types_pkg::word_16    write_data,
	output types_pkg::word_16    rd1,
	output types_pkg::word_16    rd2,
	output types_pkg::word_16    dbg_data
);
	import types_pkg::*;

	word_16 regs [NUM_REGS];

	// Single write port
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_address] <= write_data;
		end
	end

	// Operand reads
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];
	// Debug read for the outside
	assign dbg_data = regs[dbg_addr];
endmodule

// File: hw/control_main.sv
`timescale 1ns/1ps

module control_main (
	input  types_pkg::word_16 instruction,
	input  logic              rd_zero,
	output types_pkg::ctrl_t  ctrl,
	output logic              skip
);
	import types_pkg::*;
	import alu_pkg::*;

	instr_t ins;

	assign ins = instr_t'(instruction);

	always_comb begin
		ctrl = '0;
		// Load immediate rides through pass b
		ctrl.alu_func = alu_pass_b;
		case (ins.opcode)
			op_alu: begin
				ctrl.reg_wr = 1'b1;
				// func field to ALU function
				case (ins.func)
					4'h0: ctrl.alu_func = alu_add;
					4'h1: ctrl.alu_func = alu_sub;
					4'h2: ctrl.alu_func = alu_and;
					4'h3: ctrl.alu_func = alu_or;
					4'h4: ctrl.alu_func = alu_xor;
					4'h5: ctrl.alu_func = alu_shl;
					4'h6: ctrl.alu_func = alu_shr;
					default: ctrl.alu_func = alu_pass_b;
				endcase
			end
			op_li: begin
				ctrl.reg_wr = 1'b1;
				ctrl.imm_sel = 1'b1;
			end
			op_skz: ctrl.skip_test = 1'b1;
			op_halt: ctrl.halt = 1'b1;
			// Anything else retires with no effect
			default: ;
		endcase
	end

	// Only skip test in the core
	assign skip = ctrl.skip_test && rd_zero;
endmodule

// File: hw/reg_program_counter.sv
`timescale 1ns/1ps

module reg_program_counter (
	input  logic            clk,
	input  logic            reset,
	input  logic            restart,
	input  logic            run,
	input  logic            halt_exec,
	input  logic            skip,
	output types_pkg::uword out_address
);
	import types_pkg::*;

	uword pc;
	uword next_seq;
	uword next_skip;

	// Plain step and skip-over step
	assign next_seq = pc + 16'd2;
	assign next_skip = pc + 16'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (restart) begin
			pc <= '0;
		end else if (run && !halt_exec) begin
			pc <= skip ? next_skip : next_seq;
		end
		// PC parks on the halt word otherwise
	end

	assign out_address = pc;
endmodule

// File: hw/mem_program.sv
`timescale 1ns/1ps

module mem_program (
	input  logic                  clk,
	input  logic                  we,
	input  types_pkg::prog_addr_t waddr,
	input  types_pkg::word_16     wdata,
	input  types_pkg::uword       address,
	output types_pkg::word_16     data_out
);
	import types_pkg::*;

	word_16 words [PROG_DEPTH];

	// Program load port
	always_ff @(posedge clk) begin
		if (we) begin
			words[waddr] <= wdata;
		end
	end

	// Fetch by word index
	// Low address bit ignored
	assign data_out = words[address[PROG_AW:1]];
endmodule

// File: hw/prog_loader.sv
`timescale 1ns/1ps

module prog_loader (
	input  logic                clk,
	input  logic                reset,
	input  types_pkg::load_t    load,
	input  logic                start,
	input  logic                halt_exec,
	output logic                mem_we,
	output types_pkg::prog_addr_t mem_addr,
	output types_pkg::word_16   mem_data,
	output logic                run,
	output logic                restart
);
	typedef enum logic [1:0] {
		st_idle,
		st_running,
		st_halted
	} state_e;

	state_e state;
	state_e state_next;
	logic accept;

	// Loads and start only count outside execution
	assign accept = (state != st_running);
	assign mem_we = load.valid && accept;
	assign mem_addr = load.addr;
	assign mem_data = load.data;
	// Same edge that enters running also zeroes the PC
	assign restart = start && accept;
	assign run = (state == st_running);

	always_comb begin
		state_next = state;
		case (state)
			st_idle, st_halted: begin
				if (start) begin
					state_next = st_running;
				end
			end
			// Halt seen during the fetch cycle ends the run
			st_running: begin
				if (halt_exec) begin
					state_next = st_halted;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end
endmodule

// File: hw/types_pkg.sv
package types_pkg;
	// Program store size in words
	localparam int PROG_DEPTH = 256;
	localparam int PROG_AW = $clog2(PROG_DEPTH);
	localparam int NUM_REGS = 16;
	localparam int REG_AW = $clog2(NUM_REGS);

	typedef logic [15:0] word_16;
	// Byte address into program memory
	typedef logic [15:0] uword;
	typedef logic [REG_AW-1:0] reg_addr_t;
	typedef logic [PROG_AW-1:0] prog_addr_t;

	// Unlisted codes run as no-ops
	typedef enum logic [3:0] {
		op_alu  = 4'h1,
		op_li   = 4'h2,
		op_skz  = 4'h3,
		op_halt = 4'hf
	} opcode_t;

	// Field view of one instruction word
	// imm8 overlays rb and func
	typedef struct packed {
		opcode_t    opcode;
		reg_addr_t  rd;
		reg_addr_t  rb;
		logic [3:0] func;
	} instr_t;

	// One program write at a word index
	typedef struct packed {
		logic       valid;
		prog_addr_t addr;
		word_16     data;
	} load_t;

	// Decoded control word
	typedef struct packed {
		logic              reg_wr;
		logic              imm_sel;
		logic              skip_test;
		logic              halt;
		alu_pkg::control_e alu_func;
	} ctrl_t;
endpackage

// File: hw/alu_pkg.sv
package alu_pkg;
	// Datapath width seen by the ALU
	localparam int ALU_W = 16;

	// ALU functions as coded in the func field
	typedef enum logic [3:0] {
		alu_add    = 4'h0,
		alu_sub    = 4'h1,
		alu_and    = 4'h2,
		alu_or     = 4'h3,
		alu_xor    = 4'h4,
		// Shifts by one place on operand a
		alu_shl    = 4'h5,
		alu_shr    = 4'h6,
		alu_pass_b = 4'h7
	} control_e;

	// Operand pair
	typedef struct packed {
		logic [ALU_W-1:0] a;
		logic [ALU_W-1:0] b;
	} in_t;

	// Result flags
	typedef struct packed {
		logic zero;
		logic carry;
		logic negative;
		logic overflow;
	} status_t;
endpackage
